// ==== hw/xbar_consts.svh ====
// ========================================
// stream crossbar sizes
// port counts, word width and the width
// of the collision counter
// ========================================

`ifndef XBAR_CONSTS_SVH
`define XBAR_CONSTS_SVH

// input and output port counts
`define XBAR_NUM_INPUTS  4
`define XBAR_NUM_OUTPUTS 4

`define XBAR_DATAW       16
`define XBAR_CTR_BITS    16

`endif

// ==== hw/xbar_pkg.sv ====
// ========================================
// stream crossbar types
// port indices, words, counter, fill state
// ========================================

`default_nettype none

`include "xbar_consts.svh"

package xbar_pkg;

    typedef logic [$clog2(`XBAR_NUM_INPUTS)-1:0]  in_idx_t;
    typedef logic [$clog2(`XBAR_NUM_OUTPUTS)-1:0] out_idx_t;
    typedef logic [`XBAR_DATAW-1:0]               data_t;
    typedef logic [`XBAR_CTR_BITS-1:0]            ctr_t;

    // fill level of one output buffer
    typedef enum logic [1:0] {
        BUF_EMPTY = 2'd0,
        BUF_ONE   = 2'd1,
        BUF_TWO   = 2'd2
    } buf_state_e;

endpackage

`default_nettype wire

// ==== hw/xbar_stream_if.sv ====
// ========================================
// arbitrated stream between an output
// arbiter and its output buffer
// ========================================

`timescale 1ns/1ns
`default_nettype none

interface xbar_stream_if ();
    import xbar_pkg::*;

    logic    valid;
    data_t   data;
    // index of the input the word came from
    in_idx_t src_idx;
    logic    ready;

    // arbiter side
    modport src (
        output valid,
        output data,
        output src_idx,
        input  ready
    );

    // buffer side
    modport dst (
        input  valid,
        input  data,
        input  src_idx,
        output ready
    );

endinterface

`default_nettype wire

// ==== hw/xbar_route.sv ====
// ========================================
// crossbar routing
// destination decode into per-output
// requests, grants folded into ready_in
// ========================================

`timescale 1ns/1ns
`default_nettype none

`include "xbar_consts.svh"

module xbar_route (
    input  wire [`XBAR_NUM_INPUTS-1:0]                     valid_in,
    input  wire xbar_pkg::out_idx_t [`XBAR_NUM_INPUTS-1:0] sel_in,
    input  wire [`XBAR_NUM_OUTPUTS-1:0][`XBAR_NUM_INPUTS-1:0] grant,
    output logic [`XBAR_NUM_OUTPUTS-1:0][`XBAR_NUM_INPUTS-1:0] req,
    output logic [`XBAR_NUM_INPUTS-1:0]                    ready_in
);
    import xbar_pkg::*;

    // demux each valid onto its destination, already transposed
    // so that req[o] lists the inputs aimed at output o
    always_comb begin
        for (int o = 0; o < `XBAR_NUM_OUTPUTS; o++) begin
            for (int i = 0; i < `XBAR_NUM_INPUTS; i++) begin
                req[o][i] = valid_in[i] && (sel_in[i] == out_idx_t'(o));
            end
        end
    end

    // an arbiter only grants inputs that request it, so at most
    // one grant per input can be set
    always_comb begin
        for (int i = 0; i < `XBAR_NUM_INPUTS; i++) begin
            ready_in[i] = 1'b0;
            for (int o = 0; o < `XBAR_NUM_OUTPUTS; o++) begin
                ready_in[i] = ready_in[i] | grant[o][i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/xbar_rr_arb.sv ====
// ========================================
// round-robin arbiter for one output
// grants one requesting input and forwards
// its word and index
// ========================================

`timescale 1ns/1ns
`default_nettype none

`include "xbar_consts.svh"

module xbar_rr_arb (
    input  wire                                         clk,
    input  wire                                         reset,
    input  wire [`XBAR_NUM_INPUTS-1:0]                  req,
    input  wire xbar_pkg::data_t [`XBAR_NUM_INPUTS-1:0] data_in,
    output logic [`XBAR_NUM_INPUTS-1:0]                 grant,
    xbar_stream_if.src                                  out
);
    import xbar_pkg::*;

    // input with the highest priority
    in_idx_t ptr;
    in_idx_t pick;
    in_idx_t cand;
    logic    any_req;
    logic    xfer;

    assign any_req = |req;
    assign xfer    = any_req && out.ready;

    // walk the ring backwards from ptr+N-1 down to ptr so that the
    // last hit is the first requester at or after the pointer
    // index arithmetic wraps in the 2-bit type
    always_comb begin
        pick = ptr;
        cand = ptr;
        for (int k = `XBAR_NUM_INPUTS - 1; k >= 0; k--) begin
            cand = ptr + in_idx_t'(k);
            if (req[cand]) begin
                pick = cand;
            end
        end
    end

    // grant only when the buffer can take the word
    always_comb begin
        grant = '0;
        if (xfer) begin
            grant[pick] = 1'b1;
        end
    end

    assign out.valid   = any_req;
    assign out.data    = data_in[pick];
    assign out.src_idx = pick;

    // winner drops to lowest priority after a transfer
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (xfer) begin
            ptr <= pick + in_idx_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== hw/xbar_out_buf.sv ====
// ========================================
// two-entry skid buffer for one output
// registered output, full throughput
// ========================================

`timescale 1ns/1ns
`default_nettype none

module xbar_out_buf (
    input  wire              clk,
    input  wire              reset,
    xbar_stream_if.dst       in,
    output logic             valid_out,
    output xbar_pkg::data_t  data_out,
    output xbar_pkg::in_idx_t sel_out,
    input  wire              ready_out
);
    import xbar_pkg::*;

    buf_state_e state;
    // head drives the output, skid catches one extra word
    data_t      head_data;
    in_idx_t    head_src;
    data_t      skid_data;
    in_idx_t    skid_src;
    logic       push;
    logic       pop;

    // decoded straight from the state flops
    assign in.ready  = (state != BUF_TWO);
    assign valid_out = (state != BUF_EMPTY);
    assign data_out  = head_data;
    assign sel_out   = head_src;

    assign push = in.valid && in.ready;
    assign pop  = valid_out && ready_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= BUF_EMPTY;
        end else begin
            case (state)
                BUF_EMPTY: if (push) state <= BUF_ONE;
                BUF_ONE: begin
                    if (push && !pop) begin
                        state <= BUF_TWO;
                    end else if (pop && !push) begin
                        state <= BUF_EMPTY;
                    end
                end
                BUF_TWO:   if (pop) state <= BUF_ONE;
                default:   state <= BUF_EMPTY;
            endcase
        end
    end

    // head takes the new word when it is empty or drained in the same cycle
    // skid takes it only while the head stays put
    always_ff @(posedge clk) begin
        if (push && (state == BUF_EMPTY || (state == BUF_ONE && pop))) begin
            head_data <= in.data;
            head_src  <= in.src_idx;
        end else if (pop && state == BUF_TWO) begin
            head_data <= skid_data;
            head_src  <= skid_src;
        end
        if (push && !pop && state == BUF_ONE) begin
            skid_data <= in.data;
            skid_src  <= in.src_idx;
        end
    end

endmodule

`default_nettype wire

// ==== hw/xbar_collision_ctr.sv ====
// ========================================
// input collision counter
// counts inputs contending for an output
// in cycles where one of them is accepted
// ========================================

`timescale 1ns/1ns
`default_nettype none

`include "xbar_consts.svh"

module xbar_collision_ctr (
    input  wire                                            clk,
    input  wire                                            reset,
    input  wire [`XBAR_NUM_INPUTS-1:0]                     valid_in,
    input  wire xbar_pkg::out_idx_t [`XBAR_NUM_INPUTS-1:0] sel_in,
    input  wire [`XBAR_NUM_INPUTS-1:0]                     ready_in,
    output xbar_pkg::ctr_t                                 collisions
);
    import xbar_pkg::*;

    localparam int CNT_W = $clog2(`XBAR_NUM_INPUTS + 1);

    logic [`XBAR_NUM_INPUTS-1:0] hit;
    logic [`XBAR_NUM_INPUTS-1:0] hit_r;
    logic [CNT_W-1:0]            hit_count;

    // input i is marked once per cycle, whatever the number of partners
    always_comb begin
        hit = '0;
        for (int i = 0; i < `XBAR_NUM_INPUTS; i++) begin
            for (int j = i + 1; j < `XBAR_NUM_INPUTS; j++) begin
                if (valid_in[i] && valid_in[j] && (sel_in[i] == sel_in[j])
                    && (ready_in[i] || ready_in[j])) begin
                    hit[i] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        hit_count = '0;
        for (int i = 0; i < `XBAR_NUM_INPUTS; i++) begin
            hit_count = hit_count + CNT_W'(hit_r[i]);
        end
    end

    // one stage for the mark vector, one for the sum
    always_ff @(posedge clk) begin
        if (reset) begin
            hit_r      <= '0;
            collisions <= '0;
        end else begin
            hit_r      <= hit;
            collisions <= collisions + ctr_t'(hit_count);
        end
    end

endmodule

`default_nettype wire

// ==== hw/stream_xbar.sv ====
// ========================================
// 4x4 stream crossbar
// round-robin arbitration per output,
// buffered outputs, collision counter
// ========================================

`timescale 1ns/1ns
`default_nettype none

`include "xbar_consts.svh"

module stream_xbar (
    input  wire                                             clk,
    input  wire                                             reset,
    input  wire [`XBAR_NUM_INPUTS-1:0]                      valid_in,
    input  wire xbar_pkg::data_t [`XBAR_NUM_INPUTS-1:0]     data_in,
    input  wire xbar_pkg::out_idx_t [`XBAR_NUM_INPUTS-1:0]  sel_in,
    output logic [`XBAR_NUM_INPUTS-1:0]                     ready_in,
    output logic [`XBAR_NUM_OUTPUTS-1:0]                    valid_out,
    output xbar_pkg::data_t [`XBAR_NUM_OUTPUTS-1:0]         data_out,
    output xbar_pkg::in_idx_t [`XBAR_NUM_OUTPUTS-1:0]       sel_out,
    input  wire [`XBAR_NUM_OUTPUTS-1:0]                     ready_out,
    output xbar_pkg::ctr_t                                  collisions
);

    logic [`XBAR_NUM_OUTPUTS-1:0][`XBAR_NUM_INPUTS-1:0] req;
    logic [`XBAR_NUM_OUTPUTS-1:0][`XBAR_NUM_INPUTS-1:0] grant;

    xbar_route i_route (
        .valid_in (valid_in),
        .sel_in   (sel_in),
        .grant    (grant),
        .req      (req),
        .ready_in (ready_in)
    );

    // one arbiter and one buffer per output
    for (genvar o = 0; o < `XBAR_NUM_OUTPUTS; o++) begin : g_out
        xbar_stream_if stream ();

        xbar_rr_arb i_arb (
            .clk     (clk),
            .reset   (reset),
            .req     (req[o]),
            .data_in (data_in),
            .grant   (grant[o]),
            .out     (stream.src)
        );

        xbar_out_buf i_buf (
            .clk       (clk),
            .reset     (reset),
            .in        (stream.dst),
            .valid_out (valid_out[o]),
            .data_out  (data_out[o]),
            .sel_out   (sel_out[o]),
            .ready_out (ready_out[o])
        );
    end

    xbar_collision_ctr i_collision_ctr (
        .clk        (clk),
        .reset      (reset),
        .valid_in   (valid_in),
        .sel_in     (sel_in),
        .ready_in   (ready_in),
        .collisions (collisions)
    );

endmodule

`default_nettype wire

// ==== tests/tb_stream_xbar.sv ====
// ========================================
// stream crossbar testbench
// random traffic against a reference model
// ========================================

`timescale 1ns/1ns
`default_nettype none

`include "xbar_consts.svh"

module tb_stream_xbar;
    import xbar_pkg::*;

    localparam int NI             = `XBAR_NUM_INPUTS;
    localparam int NO             = `XBAR_NUM_OUTPUTS;
    localparam int TEST_CYCLES    = 2000;
    localparam int DRAIN_CYCLES   = 50;
    localparam int STALL_START    = 1000;
    localparam int STALL_LEN      = 40;
    localparam int MAX_WAIT       = 100;
    // reset, traffic and drain with margin
    localparam int TIMEOUT_CYCLES = 2500;

    logic                  clk;
    logic                  reset;
    logic [NI-1:0]         valid_in;
    data_t [NI-1:0]        data_in;
    out_idx_t [NI-1:0]     sel_in;
    logic [NI-1:0]         ready_in;
    logic [NO-1:0]         valid_out;
    data_t [NO-1:0]        data_out;
    in_idx_t [NO-1:0]      sel_out;
    logic [NO-1:0]         ready_out;
    ctr_t                  collisions;

    // model state with one queue pair per output
    data_t         q_data [NO][$];
    in_idx_t       q_src [NO][$];
    in_idx_t       rr_ptr [NO];
    ctr_t          exp_ctr;
    int            hits_d1;
    logic [NI-1:0] accepted;
    int            wait_cnt [NI];
    int            rate [NI];
    int            n_checks = 0;
    int            n_errors = 0;
    int            cycle_count = 0;

    stream_xbar i_stream_xbar (
        .clk        (clk),
        .reset      (reset),
        .valid_in   (valid_in),
        .data_in    (data_in),
        .sel_in     (sel_in),
        .ready_in   (ready_in),
        .valid_out  (valid_out),
        .data_out   (data_out),
        .sel_out    (sel_out),
        .ready_out  (ready_out),
        .collisions (collisions)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        n_checks++;
        if (expected !== actual) begin
            n_errors++;
            $display("** Error %s: expected 0x%0h, actual 0x%0h at %0t", name, expected,
                     actual, $time);
        end
    endtask

    // retire accepted words, then maybe start new ones on idle inputs
    task automatic drive_inputs(input bit allow_new);
        for (int i = 0; i < NI; i++) begin
            if (accepted[i]) begin
                valid_in[i] = 1'b0;
            end
            if (!valid_in[i] && allow_new && ($urandom_range(99) < rate[i])) begin
                valid_in[i] = 1'b1;
                data_in[i]  = data_t'($urandom);
                sel_in[i]   = out_idx_t'($urandom_range(NO - 1));
            end
        end
    endtask

    always @(posedge clk) begin : model
        logic [NI-1:0] exp_ready;
        logic [NI-1:0] req_o;
        int            fill [NO];
        in_idx_t       cand;
        logic          found;
        int            hits;

        if (reset) begin
            for (int o = 0; o < NO; o++) begin
                q_data[o].delete();
                q_src[o].delete();
                rr_ptr[o] = '0;
            end
            for (int i = 0; i < NI; i++) begin
                wait_cnt[i] = 0;
            end
            exp_ctr  = '0;
            hits_d1  = 0;
            accepted = '0;
        end else begin
            // buffer fill equals the words accepted but not yet sent
            exp_ready = '0;
            for (int o = 0; o < NO; o++) begin
                fill[o] = q_data[o].size();
                found   = 1'b0;
                for (int i = 0; i < NI; i++) begin
                    req_o[i] = valid_in[i] && (sel_in[i] == out_idx_t'(o));
                end
                for (int k = 0; k < NI; k++) begin
                    cand = rr_ptr[o] + in_idx_t'(k);
                    if (!found && req_o[cand] && fill[o] < 2) begin
                        found           = 1'b1;
                        exp_ready[cand] = 1'b1;
                    end
                end
                for (int i = 0; i < NI; i++) begin
                    if (exp_ready[i] && req_o[i]) begin
                        rr_ptr[o] = in_idx_t'(i) + in_idx_t'(1);
                    end
                end
            end
            check_value("ready_in", 32'(exp_ready), 32'(ready_in));

            for (int o = 0; o < NO; o++) begin
                check_value($sformatf("valid_out[%0d]", o), 32'(fill[o] != 0),
                            32'(valid_out[o]));
                if (valid_out[o] && ready_out[o] && fill[o] != 0) begin
                    check_value($sformatf("data_out[%0d]", o), 32'(q_data[o][0]),
                                32'(data_out[o]));
                    check_value($sformatf("sel_out[%0d]", o), 32'(q_src[o][0]),
                                32'(sel_out[o]));
                    void'(q_data[o].pop_front());
                    void'(q_src[o].pop_front());
                end
            end

            for (int i = 0; i < NI; i++) begin
                if (valid_in[i] && ready_in[i]) begin
                    q_data[sel_in[i]].push_back(data_in[i]);
                    q_src[sel_in[i]].push_back(in_idx_t'(i));
                    wait_cnt[i] = 0;
                end else if (valid_in[i]) begin
                    wait_cnt[i]++;
                    if (wait_cnt[i] == MAX_WAIT) begin
                        n_errors++;
                        $display("input %0d held valid for %0d cycles and was never accepted",
                                 i, MAX_WAIT);
                    end
                end
            end
            accepted = valid_in & ready_in;

            // pairs of valid inputs on one output where either side is accepted
            hits = 0;
            for (int i = 0; i < NI; i++) begin
                found = 1'b0;
                for (int j = i + 1; j < NI; j++) begin
                    if (valid_in[i] && valid_in[j] && (sel_in[i] == sel_in[j])
                        && (exp_ready[i] || exp_ready[j])) begin
                        found = 1'b1;
                    end
                end
                if (found) begin
                    hits++;
                end
            end
            check_value("collisions", 32'(exp_ctr), 32'(collisions));
            exp_ctr = exp_ctr + ctr_t'(hits_d1);
            hits_d1 = hits;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        reset     = 1'b1;
        valid_in  = '0;
        data_in   = '0;
        sel_in    = '0;
        ready_out = '0;
        void'($urandom(80));
        for (int i = 0; i < NI; i++) begin
            rate[i] = $urandom_range(90, 20);
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("reset valid_out", 32'd0, 32'(valid_out));
        check_value("reset collisions", 32'd0, 32'(collisions));

        for (int c = 0; c < TEST_CYCLES; c++) begin
            drive_inputs(1'b1);
            for (int o = 0; o < NO; o++) begin
                ready_out[o] = ($urandom_range(99) < 70);
            end
            // long back-pressure so every buffer fills up
            if (c >= STALL_START && c < STALL_START + STALL_LEN) begin
                ready_out = '0;
            end
            @(negedge clk);
        end

        ready_out = '1;
        for (int c = 0; c < DRAIN_CYCLES; c++) begin
            drive_inputs(1'b0);
            @(negedge clk);
        end
        if (valid_in != '0) begin
            n_errors++;
            $display("inputs still waiting after the drain: 0x%0h", valid_in);
        end
        for (int o = 0; o < NO; o++) begin
            if (q_data[o].size() != 0) begin
                n_errors++;
                $display("output %0d still owes %0d words after the drain", o,
                         q_data[o].size());
            end
        end

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hw
hw/xbar_pkg.sv
hw/xbar_stream_if.sv
hw/xbar_route.sv
hw/xbar_rr_arb.sv
hw/xbar_out_buf.sv
hw/xbar_collision_ctr.sv
hw/stream_xbar.sv
tests/tb_stream_xbar.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the stream crossbar testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -f filelist.f --top-module tb_stream_xbar -o tb_stream_xbar
./obj_dir/tb_stream_xbar | tee "$LOG"

if grep -q "^Done: no errors$" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
